/* logic/exec_pkg.sv */
package exec_pkg;

  // instruction class, chosen by decode
  typedef enum logic [3:0] {
    op_alu    = 4'd0,
    op_load   = 4'd1,
    op_store  = 4'd2,
    op_branch = 4'd3,
    op_jump   = 4'd4,
    op_csr    = 4'd5,
    op_ecall  = 4'd6,
    op_mret   = 4'd7,
    op_ebreak = 4'd8
  } op_class_e;

  typedef enum logic [3:0] {
    alu_add  = 4'd0,
    alu_sub  = 4'd1,
    alu_and  = 4'd2,
    alu_or   = 4'd3,
    alu_xor  = 4'd4,
    alu_sll  = 4'd5,
    alu_srl  = 4'd6,
    alu_sra  = 4'd7,
    alu_slt  = 4'd8,
    alu_sltu = 4'd9,
    alu_sge  = 4'd10,
    alu_sgeu = 4'd11
  } alu_op_e;

  // immediate forms arrive with the zimm already in src1
  typedef enum logic [1:0] {
    csrrw = 2'd0,
    csrrs = 2'd1,
    csrrc = 2'd2
  } csr_op_e;

  typedef logic [11:0] csr_addr_t;

  localparam csr_addr_t csr_mstatus = 12'h300;
  localparam csr_addr_t csr_mtvec   = 12'h305;
  localparam csr_addr_t csr_mepc    = 12'h341;
  localparam csr_addr_t csr_mcause  = 12'h342;

  localparam int mstatus_mie  = 3;  // bit positions inside mstatus
  localparam int mstatus_mpie = 7;

  typedef enum logic [1:0] {
    st_idle       = 2'd0,
    st_mem        = 2'd1,
    st_wait_ready = 2'd2
  } exu_state_e;

  localparam int unsigned cause_ecall_m = 11;  // environment call from m-mode

endpackage

/* logic/alu.sv */
`timescale 1ns/10ps

module alu #(
  parameter int xlen = 64
) (
  input  logic [xlen-1:0]         a_i,
  input  logic [xlen-1:0]         b_i,
  input  exec_pkg::alu_op_e       op_i,
  output logic [xlen-1:0]         res_o
);
  import exec_pkg::*;

  logic [5:0] shamt;
  logic       lt_s;
  logic       lt_u;

  assign shamt = b_i[5:0];  // rv64 shift amount
  assign lt_s  = $signed(a_i) < $signed(b_i);
  assign lt_u  = a_i < b_i;

  always_comb begin
    case (op_i)
      alu_add:  res_o = a_i + b_i;
      alu_sub:  res_o = a_i - b_i;
      alu_and:  res_o = a_i & b_i;
      alu_or:   res_o = a_i | b_i;
      alu_xor:  res_o = a_i ^ b_i;
      alu_sll:  res_o = a_i << shamt;
      alu_srl:  res_o = a_i >> shamt;
      alu_sra:  res_o = $unsigned($signed(a_i) >>> shamt);
      // compares put the flag in bit 0
      alu_slt:  res_o = {{(xlen-1){1'b0}}, lt_s};
      alu_sltu: res_o = {{(xlen-1){1'b0}}, lt_u};
      alu_sge:  res_o = {{(xlen-1){1'b0}}, ~lt_s};
      alu_sgeu: res_o = {{(xlen-1){1'b0}}, ~lt_u};
      default:  res_o = '0;
    endcase
  end

endmodule

/* logic/csr_file.sv */
`timescale 1ns/10ps

module csr_file #(
  parameter int xlen = 64
) (
  input  logic                clk,
  input  logic                rst,
  input  exec_pkg::csr_addr_t raddr_i,
  input  logic                we_i,
  input  exec_pkg::csr_addr_t waddr_i,
  input  logic [xlen-1:0]     wdata_i,
  input  logic                ecall_we_i,
  input  logic [xlen-1:0]     ecall_pc_i,
  output logic [xlen-1:0]     rdata_o,
  output logic [xlen-1:0]     mtvec_o,
  output logic [xlen-1:0]     mepc_o
);
  import exec_pkg::*;

  logic [xlen-1:0] mstatus;
  logic [xlen-1:0] mtvec;
  logic [xlen-1:0] mepc;
  logic [xlen-1:0] mcause;

  always_ff @(posedge clk) begin
    if (rst) begin
      mstatus <= '0;
      mtvec   <= '0;
      mepc    <= '0;
      mcause  <= '0;
    end else begin
      if (we_i) begin
        case (waddr_i)
          csr_mstatus: mstatus <= wdata_i;
          csr_mtvec:   mtvec   <= wdata_i;
          csr_mepc:    mepc    <= wdata_i;
          csr_mcause:  mcause  <= wdata_i;
          default: ;  // unknown csr, dropped
        endcase
      end
      // trap entry side write, wins over the general port
      if (ecall_we_i) begin
        mepc   <= ecall_pc_i;
        mcause <= xlen'(cause_ecall_m);
      end
    end
  end

  always_comb begin
    case (raddr_i)
      csr_mstatus: rdata_o = mstatus;
      csr_mtvec:   rdata_o = mtvec;
      csr_mepc:    rdata_o = mepc;
      csr_mcause:  rdata_o = mcause;
      default:     rdata_o = '0;
    endcase
  end

  assign mtvec_o = mtvec;  // trap vector for ecall redirect
  assign mepc_o  = mepc;

endmodule

/* logic/exu_stage.sv */
`timescale 1ns/10ps

module exu_stage #(
  parameter int xlen = 64
) (
  input  logic                clk,
  input  logic                rst,
  // upstream
  input  logic                in_valid_i,
  output logic                in_ready_o,
  input  exec_pkg::op_class_e op_class_i,
  input  exec_pkg::alu_op_e   alu_op_i,
  input  exec_pkg::csr_op_e   csr_op_i,
  input  exec_pkg::csr_addr_t csr_addr_i,
  input  logic [4:0]          rd_i,
  input  logic                rwen_i,
  input  logic [xlen-1:0]     pc_i,
  input  logic [xlen-1:0]     src1_i,
  input  logic [xlen-1:0]     src2_i,
  input  logic [xlen-1:0]     base_i,
  input  logic [xlen-1:0]     imm_i,
  // downstream
  output logic                out_valid_o,
  input  logic                out_ready_i,
  output logic [4:0]          rd_o,
  output logic                rwen_o,
  output logic [xlen-1:0]     wdata_o,
  output logic                redirect_o,
  output logic [xlen-1:0]     npc_o,
  output logic                ebreak_o,
  // alu
  output exec_pkg::alu_op_e   alu_op_o,
  output logic [xlen-1:0]     alu_a_o,
  output logic [xlen-1:0]     alu_b_o,
  input  logic [xlen-1:0]     alu_res_i,
  // csr file
  output exec_pkg::csr_addr_t csr_raddr_o,
  output logic                csr_we_o,
  output exec_pkg::csr_addr_t csr_waddr_o,
  output logic [xlen-1:0]     csr_wdata_o,
  output logic                ecall_we_o,
  output logic [xlen-1:0]     ecall_pc_o,
  input  logic [xlen-1:0]     csr_rdata_i,
  input  logic [xlen-1:0]     mtvec_i,
  input  logic [xlen-1:0]     mepc_i,
  // data memory
  output logic                mem_req_o,
  output logic                mem_we_o,
  output logic [xlen-1:0]     mem_addr_o,
  output logic [xlen-1:0]     mem_wdata_o,
  input  logic                mem_ack_i,
  input  logic [xlen-1:0]     mem_rdata_i
);
  import exec_pkg::*;

  exu_state_e      state_q;
  exu_state_e      state_d;
  op_class_e       cls_q;
  alu_op_e         alu_op_q;
  csr_op_e         csr_op_q;
  csr_addr_t       csr_addr_q;
  logic [4:0]      rd_q;
  logic            rwen_q;
  logic [xlen-1:0] pc_q;
  logic [xlen-1:0] src1_q;
  logic [xlen-1:0] src2_q;
  logic [xlen-1:0] target_q;
  logic [xlen-1:0] load_q;
  logic            accept;
  logic            complete;
  logic            is_mem;
  logic            taken;
  logic            redirect;
  logic [xlen-1:0] csr_new;
  logic [xlen-1:0] mret_status;

  assign accept   = in_valid_i & in_ready_o;
  assign complete = out_valid_o & out_ready_i;
  assign is_mem   = (op_class_i == op_load) || (op_class_i == op_store);

  always_comb begin
    state_d = state_q;
    case (state_q)
      st_idle:       if (accept) state_d = is_mem ? st_mem : st_wait_ready;
      st_mem:        if (mem_ack_i) state_d = st_wait_ready;  // ack sampled, req drops
      st_wait_ready: if (out_ready_i) state_d = st_idle;
      default:       state_d = st_idle;
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state_q <= st_idle;
    end else begin
      state_q <= state_d;
    end
  end

  always_ff @(posedge clk) begin
    if (accept) begin
      cls_q      <= op_class_i;
      alu_op_q   <= alu_op_i;
      csr_op_q   <= csr_op_i;
      csr_addr_q <= csr_addr_i;
      rd_q       <= rd_i;
      rwen_q     <= rwen_i;
      pc_q       <= pc_i;
      src1_q     <= src1_i;
      src2_q     <= src2_i;
      target_q   <= base_i + imm_i;  // mem address and jump/branch target
    end
    if (mem_req_o && mem_ack_i) begin
      load_q <= mem_rdata_i;
    end
  end

  assign in_ready_o  = (state_q == st_idle);
  assign out_valid_o = (state_q == st_wait_ready);
  assign mem_req_o   = (state_q == st_mem);
  assign mem_we_o    = mem_req_o & (cls_q == op_store);
  assign mem_addr_o  = target_q;
  assign mem_wdata_o = src2_q;

  assign alu_op_o = alu_op_q;
  assign alu_a_o  = src1_q;
  assign alu_b_o  = src2_q;

  // branch condition from the alu result
  always_comb begin
    case (alu_op_q)
      alu_sub:                              taken = (alu_res_i == '0);  // beq
      alu_xor:                              taken = (alu_res_i != '0);  // bne
      alu_slt, alu_sltu, alu_sge, alu_sgeu: taken = alu_res_i[0];
      default:                              taken = 1'b0;
    endcase
  end

  always_comb begin
    redirect = 1'b0;
    npc_o    = target_q;
    case (cls_q)
      op_branch: redirect = taken;
      op_jump:   redirect = 1'b1;
      op_ecall: begin
        redirect = 1'b1;
        npc_o    = mtvec_i;
      end
      op_mret: begin
        redirect = 1'b1;
        npc_o    = mepc_i;
      end
      op_ebreak: begin
        redirect = 1'b1;
        npc_o    = pc_q;
      end
      default: ;
    endcase
  end

  assign redirect_o = out_valid_o & redirect;
  assign ebreak_o   = out_valid_o & (cls_q == op_ebreak);

  always_comb begin
    case (cls_q)
      op_load: wdata_o = load_q;
      op_csr:  wdata_o = csr_rdata_i;  // old value, csr not written until completion
      op_jump: wdata_o = pc_q + xlen'(4);
      default: wdata_o = alu_res_i;
    endcase
  end

  assign rd_o   = rd_q;
  assign rwen_o = rwen_q;

  always_comb begin
    case (csr_op_q)
      csrrs:   csr_new = csr_rdata_i | src1_q;
      csrrc:   csr_new = csr_rdata_i & ~src1_q;
      default: csr_new = src1_q;
    endcase
  end

  // mret: mie <- mpie, mpie <- 1
  always_comb begin
    mret_status               = csr_rdata_i;
    mret_status[mstatus_mie]  = csr_rdata_i[mstatus_mpie];
    mret_status[mstatus_mpie] = 1'b1;
  end

  assign csr_raddr_o = (cls_q == op_mret) ? csr_mstatus : csr_addr_q;
  assign csr_waddr_o = csr_raddr_o;
  assign csr_wdata_o = (cls_q == op_mret) ? mret_status : csr_new;
  assign csr_we_o    = complete & ((cls_q == op_csr) | (cls_q == op_mret));
  assign ecall_we_o  = complete & (cls_q == op_ecall);
  assign ecall_pc_o  = pc_q;

endmodule

/* logic/data_mem.sv */
`timescale 1ns/10ps

module data_mem #(
  parameter int xlen      = 64,
  parameter int mem_words = 256
) (
  input  logic            clk,
  input  logic            rst,
  input  logic            req_i,
  input  logic            we_i,
  input  logic [xlen-1:0] addr_i,
  input  logic [xlen-1:0] wdata_i,
  output logic            ack_o,
  output logic [xlen-1:0] rdata_o
);

  localparam int aw = $clog2(mem_words);

  logic [xlen-1:0]      mem [mem_words];
  logic [mem_words-1:0] written_q;  // words never stored read back as zero
  logic [aw-1:0]        idx;
  logic                 start;

  // byte address to word index, wraps at mem_words (power of two)
  assign idx   = addr_i[3 +: aw];
  assign start = req_i & ~ack_o;  // no second access while req is held in the ack cycle

  always_ff @(posedge clk) begin
    if (rst) begin
      ack_o     <= 1'b0;
      written_q <= '0;
    end else begin
      ack_o <= start;
      if (start && we_i) begin
        written_q[idx] <= 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (start) begin
      if (we_i) begin
        mem[idx] <= wdata_i;
      end
      rdata_o <= written_q[idx] ? mem[idx] : '0;
    end
  end

endmodule

/* logic/exec_top.sv */
`timescale 1ns/10ps

module exec_top #(
  parameter int xlen      = 64,
  parameter int mem_words = 256
) (
  input  logic                clk,
  input  logic                rst,
  input  logic                in_valid_i,
  output logic                in_ready_o,
  input  exec_pkg::op_class_e op_class_i,
  input  exec_pkg::alu_op_e   alu_op_i,
  input  exec_pkg::csr_op_e   csr_op_i,
  input  exec_pkg::csr_addr_t csr_addr_i,
  input  logic [4:0]          rd_i,
  input  logic                rwen_i,
  input  logic [xlen-1:0]     pc_i,
  input  logic [xlen-1:0]     src1_i,
  input  logic [xlen-1:0]     src2_i,
  input  logic [xlen-1:0]     base_i,
  input  logic [xlen-1:0]     imm_i,
  output logic                out_valid_o,
  input  logic                out_ready_i,
  output logic [4:0]          rd_o,
  output logic                rwen_o,
  output logic [xlen-1:0]     wdata_o,
  output logic                redirect_o,
  output logic [xlen-1:0]     npc_o,
  output logic                ebreak_o
);
  import exec_pkg::*;

  alu_op_e         alu_op;
  logic [xlen-1:0] alu_a;
  logic [xlen-1:0] alu_b;
  logic [xlen-1:0] alu_res;
  csr_addr_t       csr_raddr;
  csr_addr_t       csr_waddr;
  logic            csr_we;
  logic [xlen-1:0] csr_wdata;
  logic            ecall_we;
  logic [xlen-1:0] ecall_pc;
  logic [xlen-1:0] csr_rdata;
  logic [xlen-1:0] mtvec;
  logic [xlen-1:0] mepc;
  logic            mem_req;
  logic            mem_we;
  logic [xlen-1:0] mem_addr;
  logic [xlen-1:0] mem_wdata;
  logic            mem_ack;
  logic [xlen-1:0] mem_rdata;

  exu_stage #(.xlen(xlen)) u_exu (
    .clk(clk), .rst(rst),
    .in_valid_i(in_valid_i), .in_ready_o(in_ready_o),
    .op_class_i(op_class_i), .alu_op_i(alu_op_i), .csr_op_i(csr_op_i),
    .csr_addr_i(csr_addr_i), .rd_i(rd_i), .rwen_i(rwen_i), .pc_i(pc_i),
    .src1_i(src1_i), .src2_i(src2_i), .base_i(base_i), .imm_i(imm_i),
    .out_valid_o(out_valid_o), .out_ready_i(out_ready_i),
    .rd_o(rd_o), .rwen_o(rwen_o), .wdata_o(wdata_o),
    .redirect_o(redirect_o), .npc_o(npc_o), .ebreak_o(ebreak_o),
    .alu_op_o(alu_op), .alu_a_o(alu_a), .alu_b_o(alu_b), .alu_res_i(alu_res),
    .csr_raddr_o(csr_raddr), .csr_we_o(csr_we), .csr_waddr_o(csr_waddr),
    .csr_wdata_o(csr_wdata), .ecall_we_o(ecall_we), .ecall_pc_o(ecall_pc),
    .csr_rdata_i(csr_rdata), .mtvec_i(mtvec), .mepc_i(mepc),
    .mem_req_o(mem_req), .mem_we_o(mem_we), .mem_addr_o(mem_addr),
    .mem_wdata_o(mem_wdata), .mem_ack_i(mem_ack), .mem_rdata_i(mem_rdata)
  );

  alu #(.xlen(xlen)) u_alu (
    .a_i(alu_a), .b_i(alu_b), .op_i(alu_op), .res_o(alu_res)
  );

  csr_file #(.xlen(xlen)) u_csr (
    .clk(clk), .rst(rst),
    .raddr_i(csr_raddr), .we_i(csr_we), .waddr_i(csr_waddr), .wdata_i(csr_wdata),
    .ecall_we_i(ecall_we), .ecall_pc_i(ecall_pc),
    .rdata_o(csr_rdata), .mtvec_o(mtvec), .mepc_o(mepc)
  );

  data_mem #(.xlen(xlen), .mem_words(mem_words)) u_mem (
    .clk(clk), .rst(rst),
    .req_i(mem_req), .we_i(mem_we), .addr_i(mem_addr), .wdata_i(mem_wdata),
    .ack_o(mem_ack), .rdata_o(mem_rdata)
  );

endmodule

/* bench/exec_properties.sv */
`timescale 1ns/10ps

module exec_properties #(
  parameter int xlen = 64
) (
  input logic            clk,
  input logic            rst,
  input logic            in_ready_o,
  input logic            out_valid_o,
  input logic            out_ready_i,
  input logic [4:0]      rd_o,
  input logic            rwen_o,
  input logic [xlen-1:0] wdata_o,
  input logic            redirect_o,
  input logic [xlen-1:0] npc_o,
  input logic            ebreak_o,
  input logic            mem_req_o,
  input logic            mem_ack_i,
  input logic            csr_we_o
);

  // a stalled result keeps every field
  a_hold: assert property (@(posedge clk) disable iff (rst)
    out_valid_o && !out_ready_i |=> out_valid_o && $stable(wdata_o) && $stable(npc_o)
      && $stable(redirect_o) && $stable(ebreak_o) && $stable(rd_o) && $stable(rwen_o))
    else $error("result changed while out_ready_i was low");

  a_no_accept: assert property (@(posedge clk) disable iff (rst) out_valid_o |-> !in_ready_o)
    else $error("in_ready_o high while a result is pending");

  a_req_drop: assert property (@(posedge clk) disable iff (rst)
    mem_req_o && mem_ack_i |=> !mem_req_o)
    else $error("mem_req_o still high after the ack");

  a_req_hold: assert property (@(posedge clk) disable iff (rst)
    mem_req_o && !mem_ack_i |=> mem_req_o)
    else $error("mem_req_o dropped before the ack");

  a_csr_once: assert property (@(posedge clk) disable iff (rst)
    csr_we_o |-> out_valid_o && out_ready_i)
    else $error("csr write outside the completion cycle");

endmodule

bind exu_stage exec_properties #(.xlen(xlen)) u_props (
  .clk(clk), .rst(rst), .in_ready_o(in_ready_o), .out_valid_o(out_valid_o),
  .out_ready_i(out_ready_i), .rd_o(rd_o), .rwen_o(rwen_o), .wdata_o(wdata_o),
  .redirect_o(redirect_o), .npc_o(npc_o), .ebreak_o(ebreak_o),
  .mem_req_o(mem_req_o), .mem_ack_i(mem_ack_i), .csr_we_o(csr_we_o)
);

/* bench/tb_exec_top.sv */
`timescale 1ns/10ps

module tb_exec_top;
  import exec_pkg::*;

  localparam int n_instr      = 62;
  localparam int reset_cycles = 5;
  localparam int cycle_limit  = 40 * n_instr + reset_cycles;
  localparam int lat_short    = 1;  // handshake cycle to first valid cycle
  localparam int lat_long     = 3;  // plus the request and ack cycles
  localparam logic [63:0] addr_a    = 64'h1028;  // word 5
  localparam logic [63:0] addr_b    = 64'h0640;  // word 200
  localparam logic [63:0] addr_none = 64'h0268;  // word 77, never stored

  logic        clk;
  logic        rst;
  logic        in_valid_i;
  logic        in_ready_o;
  op_class_e   op_class_i;
  alu_op_e     alu_op_i;
  csr_op_e     csr_op_i;
  csr_addr_t   csr_addr_i;
  logic [4:0]  rd_i;
  logic        rwen_i;
  logic [63:0] pc_i;
  logic [63:0] src1_i;
  logic [63:0] src2_i;
  logic [63:0] base_i;
  logic [63:0] imm_i;
  logic        out_valid_o;
  logic        out_ready_i;
  logic [4:0]  rd_o;
  logic        rwen_o;
  logic [63:0] wdata_o;
  logic        redirect_o;
  logic [63:0] npc_o;
  logic        ebreak_o;

  int          errors;
  int          cycles;
  int          hs_cycle;
  logic [4:0]  last_rd;
  logic        last_rwen;
  logic [63:0] m_mstatus;
  logic [63:0] m_mtvec;
  logic [63:0] m_mepc;
  logic [63:0] m_mcause;
  logic [63:0] data_a;

  exec_top #(.xlen(64), .mem_words(256)) u_dut (.*);

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  always @(posedge clk) cycles <= cycles + 1;

  initial begin
    wait (cycles >= cycle_limit);
    $display("timeout after %0d cycles, the DUT stopped answering", cycles);
    $display("tests failed");
    $finish;
  end

  task automatic check(input string name, input logic [63:0] got, input logic [63:0] exp);
    if (got !== exp) begin
      errors++;
      $display("mismatch at %0t: %s is %h, expected %h", $time, name, got, exp);
    end
  endtask

  function automatic logic [63:0] rand64();
    return {$urandom, $urandom};
  endfunction

  function automatic logic [63:0] rand_pc();
    return rand64() & ~64'h3;
  endfunction

  function automatic logic [63:0] model_alu(alu_op_e op, logic [63:0] a, logic [63:0] b);
    logic signed [63:0] sa;
    logic signed [63:0] sb;
    sa = a;
    sb = b;
    case (op)
      alu_add:  return a + b;
      alu_sub:  return a + ~b + 64'd1;
      alu_and:  return a & b;
      alu_or:   return a | b;
      alu_xor:  return a ^ b;
      alu_sll:  return a << b[5:0];
      alu_srl:  return a >> b[5:0];
      alu_sra:  return sa >>> b[5:0];
      alu_slt:  return (sa < sb) ? 64'd1 : 64'd0;
      alu_sltu: return (a < b) ? 64'd1 : 64'd0;
      alu_sge:  return (sa >= sb) ? 64'd1 : 64'd0;
      alu_sgeu: return (a >= b) ? 64'd1 : 64'd0;
      default:  return 64'd0;
    endcase
  endfunction

  // beq, bne, blt, bltu, bge, bgeu by their alu encodings
  function automatic logic branch_taken(alu_op_e op, logic [63:0] a, logic [63:0] b);
    case (op)
      alu_sub:  return a == b;
      alu_xor:  return a != b;
      alu_slt:  return $signed(a) < $signed(b);
      alu_sltu: return a < b;
      alu_sge:  return $signed(a) >= $signed(b);
      alu_sgeu: return a >= b;
      default:  return 1'b0;
    endcase
  endfunction

  function automatic logic [63:0] csr_value(csr_addr_t addr);
    case (addr)
      csr_mstatus: return m_mstatus;
      csr_mtvec:   return m_mtvec;
      csr_mepc:    return m_mepc;
      csr_mcause:  return m_mcause;
      default:     return 64'd0;
    endcase
  endfunction

  task automatic csr_update(input csr_addr_t addr, input logic [63:0] val);
    case (addr)
      csr_mstatus: m_mstatus = val;
      csr_mtvec:   m_mtvec = val;
      csr_mepc:    m_mepc = val;
      csr_mcause:  m_mcause = val;
      default: ;  // unknown address keeps nothing
    endcase
  endtask

  task automatic send(input op_class_e cls, input alu_op_e aop, input csr_op_e cop,
                      input csr_addr_t addr, input logic [63:0] pc, input logic [63:0] s1,
                      input logic [63:0] s2, input logic [63:0] base, input logic [63:0] imm);
    @(negedge clk);
    last_rd    = 5'($urandom);
    last_rwen  = 1'($urandom);
    op_class_i = cls;
    alu_op_i   = aop;
    csr_op_i   = cop;
    csr_addr_i = addr;
    rd_i       = last_rd;
    rwen_i     = last_rwen;
    pc_i       = pc;
    src1_i     = s1;
    src2_i     = s2;
    base_i     = base;
    imm_i      = imm;
    in_valid_i = 1'b1;
    while (!in_ready_o) @(negedge clk);
    hs_cycle = cycles;  // taken at the coming edge
    @(negedge clk);
    in_valid_i = 1'b0;
  endtask

  task automatic collect(input int hold, input int exp_lat, input logic chk_wdata,
                         input logic [63:0] exp_wdata, input logic exp_redirect,
                         input logic chk_npc, input logic [63:0] exp_npc, input logic exp_ebreak);
    logic [63:0] first_wdata;
    logic [63:0] first_npc;
    while (!out_valid_o) @(negedge clk);
    check("latency", 64'(cycles - hs_cycle), 64'(exp_lat));
    first_wdata = wdata_o;
    first_npc   = npc_o;
    repeat (hold) @(negedge clk);
    if (hold > 0) begin
      check("out_valid_o", 64'(out_valid_o), 64'd1);
      check("wdata_o held", wdata_o, first_wdata);
      check("npc_o held", npc_o, first_npc);
    end
    if (chk_wdata) check("wdata_o", wdata_o, exp_wdata);
    if (chk_npc) check("npc_o", npc_o, exp_npc);
    check("redirect_o", 64'(redirect_o), 64'(exp_redirect));
    check("ebreak_o", 64'(ebreak_o), 64'(exp_ebreak));
    check("rd_o", 64'(rd_o), 64'(last_rd));
    check("rwen_o", 64'(rwen_o), 64'(last_rwen));
    out_ready_i = 1'b1;
    @(negedge clk);
    out_ready_i = 1'b0;
  endtask

  task automatic alu_instr(input alu_op_e op, input logic [63:0] a, input logic [63:0] b,
                           input int hold);
    send(op_alu, op, csrrw, 12'h0, rand_pc(), a, b, 64'd0, 64'd0);
    collect(hold, lat_short, 1'b1, model_alu(op, a, b), 1'b0, 1'b0, 64'd0, 1'b0);
  endtask

  task automatic store_word(input logic [63:0] addr, input logic [63:0] data);
    logic [63:0] imm;
    imm = 64'($urandom_range(0, 2047));
    send(op_store, alu_add, csrrw, 12'h0, rand_pc(), rand64(), data, addr - imm, imm);
    collect(0, lat_long, 1'b0, 64'd0, 1'b0, 1'b0, 64'd0, 1'b0);
  endtask

  task automatic load_word(input logic [63:0] addr, input logic [63:0] exp, input int hold);
    logic [63:0] imm;
    imm = 64'($urandom_range(0, 2047));
    send(op_load, alu_add, csrrw, 12'h0, rand_pc(), rand64(), rand64(), addr - imm, imm);
    collect(hold, lat_long, 1'b1, exp, 1'b0, 1'b0, 64'd0, 1'b0);
  endtask

  task automatic branch_instr(input alu_op_e op, input logic [63:0] a, input logic [63:0] b);
    logic [63:0] base;
    logic [63:0] imm;
    base = rand_pc();
    imm  = 64'($urandom_range(0, 4095)) & ~64'h3;
    send(op_branch, op, csrrw, 12'h0, rand_pc(), a, b, base, imm);
    collect(0, lat_short, 1'b0, 64'd0, branch_taken(op, a, b), 1'b1, base + imm, 1'b0);
  endtask

  task automatic jump_instr();
    logic [63:0] pc;
    logic [63:0] base;
    logic [63:0] imm;
    pc   = rand_pc();
    base = rand_pc();
    imm  = rand_pc();
    send(op_jump, alu_add, csrrw, 12'h0, pc, rand64(), rand64(), base, imm);
    collect(0, lat_short, 1'b1, pc + 64'd4, 1'b1, 1'b1, base + imm, 1'b0);
  endtask

  task automatic csr_access(input csr_op_e cop, input csr_addr_t addr, input logic [63:0] s1,
                            input int hold);
    logic [63:0] old;
    logic [63:0] upd;
    old = csr_value(addr);
    case (cop)
      csrrs:   upd = old | s1;
      csrrc:   upd = old & ~s1;
      default: upd = s1;
    endcase
    send(op_csr, alu_add, cop, addr, rand_pc(), s1, rand64(), 64'd0, 64'd0);
    collect(hold, lat_short, 1'b1, old, 1'b0, 1'b0, 64'd0, 1'b0);
    csr_update(addr, upd);
  endtask

  task automatic alu_ops();
    for (int i = 0; i < 12; i++) begin
      alu_instr(alu_op_e'(i), rand64(), rand64(), 0);
    end
  endtask

  task automatic mem_access();
    logic [63:0] data_b;
    data_a = rand64();
    data_b = rand64();
    store_word(addr_a, data_a);
    store_word(addr_b, data_b);
    load_word(addr_a, data_a, 0);
    load_word(addr_b, data_b, 0);
    load_word(addr_none, 64'd0, 0);
    load_word(addr_a + 64'h800, data_a, 0);  // wraps onto word 5
  endtask

  task automatic branches();
    alu_op_e     bops [6];
    logic [63:0] pa [4];
    logic [63:0] pb [4];
    logic [63:0] r;
    r    = rand64();
    bops = '{alu_sub, alu_xor, alu_slt, alu_sltu, alu_sge, alu_sgeu};
    pa   = '{r, 64'd5, 64'hffff_ffff_ffff_ffff, 64'd9};  // -1 vs 1 splits signed from unsigned
    pb   = '{r, 64'd9, 64'd1, 64'd5};
    foreach (bops[i]) begin
      foreach (pa[j]) begin
        branch_instr(bops[i], pa[j], pb[j]);
      end
    end
    jump_instr();
    jump_instr();
  endtask

  task automatic csr_ops();
    csr_access(csrrw, csr_mtvec, rand64() & ~64'h3, 0);
    csr_access(csrrs, csr_mtvec, 64'd0, 0);
    csr_access(csrrs, csr_mstatus, rand64(), 0);
    csr_access(csrrc, csr_mstatus, rand64(), 0);
    csr_access(csrrs, csr_mstatus, 64'd0, 0);
    csr_access(csrrw, 12'h7c0, rand64(), 0);
    csr_access(csrrs, 12'h7c0, 64'd0, 0);
  endtask

  task automatic traps();
    logic [63:0] pc;
    pc = rand_pc();
    send(op_ecall, alu_add, csrrw, 12'h0, pc, 64'd0, 64'd0, 64'd0, 64'd0);
    collect(0, lat_short, 1'b0, 64'd0, 1'b1, 1'b1, m_mtvec, 1'b0);
    m_mepc   = pc;
    m_mcause = 64'd11;  // environment call from m-mode
    csr_access(csrrs, csr_mepc, 64'd0, 0);
    csr_access(csrrs, csr_mcause, 64'd0, 0);
    csr_access(csrrw, csr_mstatus, (rand64() | 64'h80) & ~64'h8, 0);
    send(op_mret, alu_add, csrrw, 12'h0, rand_pc(), 64'd0, 64'd0, 64'd0, 64'd0);
    collect(0, lat_short, 1'b0, 64'd0, 1'b1, 1'b1, m_mepc, 1'b0);
    m_mstatus[3] = m_mstatus[7];  // mie takes mpie
    m_mstatus[7] = 1'b1;
    csr_access(csrrs, csr_mstatus, 64'd0, 0);
    pc = rand_pc();
    send(op_ebreak, alu_add, csrrw, 12'h0, pc, 64'd0, 64'd0, 64'd0, 64'd0);
    collect(0, lat_short, 1'b0, 64'd0, 1'b1, 1'b1, pc, 1'b1);
  endtask

  task automatic back_pressure();
    alu_instr(alu_add, rand64(), rand64(), $urandom_range(1, 6));
    load_word(addr_a, data_a, $urandom_range(1, 6));
    csr_access(csrrw, csr_mtvec, rand64(), $urandom_range(1, 6));
    csr_access(csrrs, csr_mtvec, 64'd0, 0);
  endtask

  initial begin
    void'($urandom(32'he0e1a034));
    errors      = 0;
    cycles      = 0;
    hs_cycle    = 0;
    m_mstatus   = 64'd0;
    m_mtvec     = 64'd0;
    m_mepc      = 64'd0;
    m_mcause    = 64'd0;
    rst         = 1'b1;
    in_valid_i  = 1'b0;
    op_class_i  = op_alu;
    alu_op_i    = alu_add;
    csr_op_i    = csrrw;
    csr_addr_i  = 12'h0;
    rd_i        = 5'd0;
    rwen_i      = 1'b0;
    pc_i        = 64'd0;
    src1_i      = 64'd0;
    src2_i      = 64'd0;
    base_i      = 64'd0;
    imm_i       = 64'd0;
    out_ready_i = 1'b0;
    repeat (reset_cycles) @(negedge clk);
    rst = 1'b0;
    check("in_ready_o", 64'(in_ready_o), 64'd1);
    check("out_valid_o", 64'(out_valid_o), 64'd0);
    check("redirect_o", 64'(redirect_o), 64'd0);
    check("ebreak_o", 64'(ebreak_o), 64'd0);
    alu_ops();
    mem_access();
    branches();
    csr_ops();
    traps();
    back_pressure();
    $display("checks done, %0d errors", errors);
    if (errors == 0) begin
      $display("all tests passed");
    end else begin
      $display("tests failed");
    end
    $finish;
  end

endmodule

/* tb.f */
logic/exec_pkg.sv
logic/alu.sv
logic/csr_file.sv
logic/exu_stage.sv
logic/data_mem.sv
logic/exec_top.sv
bench/exec_properties.sv
bench/tb_exec_top.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= tb_exec_top
FILELIST  ?= tb.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
FAIL_MSG  ?= tests failed
VFLAGS    ?= --timing --assert

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "$(FAIL_MSG)" $(LOG); then \
	  echo "simulation FAILED, see $(LOG)"; \
	  exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
